// File: cp0Pkg.sv
`default_nettype none

package cp0Pkg;

    // control kind carried by each lane, only what the memory stage needs
    typedef enum logic [1:0] {
        NONE      = 2'd0,
        EXCEPTION = 2'd1,
        ERET      = 2'd2
    } ctype_t;

endpackage

`default_nettype wire

// File: pipePkg.sv
`default_nettype none

package pipePkg;

    // response wait limit and the counter that measures it
    localparam int TIMEOUT_CYCLES = 64;
    localparam int TIMER_W = 7;

    // AXI response code for a good beat
    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef logic [31:0] word_t;
    typedef logic [3:0] strobe_t;

    typedef enum logic [1:0] {
        MSIZE1 = 2'd0,
        MSIZE2 = 2'd1,
        MSIZE4 = 2'd2
    } msize_t;

    typedef struct packed {
        logic   memToReg;
        logic   memWrite;
        logic   regWrite;
        logic   memSigned;
        msize_t msize;
    } memCtl_t;

    typedef struct packed {
        logic            valid;
        word_t           pc;
        logic [4:0]      rdst;
        word_t           aluOut;
        word_t           srcb;
        memCtl_t         ctl;
        cp0Pkg::ctype_t  ctype;
    } execData_t;

    // index 1 is the older lane
    typedef execData_t [1:0] execPair_t;

    typedef struct packed {
        logic    valid;
        word_t   addr;
        word_t   data;
        strobe_t strobe;
        msize_t  size;
        logic    isWrite;
    } dreq_t;

    typedef struct packed {
        logic            valid;
        word_t           pc;
        logic [4:0]      rdst;
        word_t           aluOut;
        word_t           srcb;
        memCtl_t         ctl;
        cp0Pkg::ctype_t  ctype;
        word_t           result;
        logic            busErr;
        // pair-level exception flag, same in both lanes
        logic            excpM;
    } memData_t;

    typedef memData_t [1:0] memPair_t;

endpackage

`default_nettype wire

// File: writeData.sv
`timescale 1ns/1ps
`default_nettype none

module writeData (
    input  logic [1:0]       addr,
    input  pipePkg::word_t   rawData,
    input  pipePkg::msize_t  msize,
    output pipePkg::word_t   wd,
    output pipePkg::strobe_t strobe
);

    always_comb begin
        case (msize)
            pipePkg::MSIZE1: begin
                // byte copied into every lane, strobe picks one
                wd = {4{rawData[7:0]}};
                strobe = 4'b0001 << addr;
            end
            pipePkg::MSIZE2: begin
                wd = {2{rawData[15:0]}};
                strobe = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wd = rawData;
                strobe = 4'b1111;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: readData.sv
`timescale 1ns/1ps
`default_nettype none

module readData (
    input  logic [1:0]      addr,
    input  pipePkg::word_t  rdata,
    input  pipePkg::msize_t msize,
    input  logic            memSigned,
    output pipePkg::word_t  loadData
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // addressed byte and half of the returned word
    assign byteSel = rdata[{addr, 3'b000} +: 8];
    assign halfSel = addr[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (msize)
            pipePkg::MSIZE1: begin
                loadData = {{24{memSigned & byteSel[7]}}, byteSel};
            end
            pipePkg::MSIZE2: begin
                loadData = {{16{memSigned & halfSel[15]}}, halfSel};
            end
            default: begin
                loadData = rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory (
    input  pipePkg::execPair_t   dataE,
    output pipePkg::dreq_t [1:0] dreq,
    output pipePkg::memCtl_t [1:0] ctlM,
    output logic                 excpM
);

    logic [1:0] laneExcp;
    logic [1:0] squash;
    pipePkg::word_t [1:0] wd;
    pipePkg::strobe_t [1:0] strobe;

    for (genvar i = 0; i < 2; i++) begin : gLane
        assign laneExcp[i] = (dataE[i].ctype == cp0Pkg::EXCEPTION) ||
                             (dataE[i].ctype == cp0Pkg::ERET);

        writeData writeDataLane (
            .addr    (dataE[i].aluOut[1:0]),
            .rawData (dataE[i].srcb),
            .msize   (dataE[i].ctl.msize),
            .wd      (wd[i]),
            .strobe  (strobe[i])
        );
    end

    // the older lane is never squashed by the younger one
    assign squash = {1'b0, laneExcp[1]};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dreq[i] = '0;
            dreq[i].valid = (dataE[i].ctl.memToReg || dataE[i].ctl.memWrite) &&
                            !squash[i] && !laneExcp[i];
            dreq[i].addr = dataE[i].aluOut;
            dreq[i].size = dataE[i].ctl.msize;
            dreq[i].isWrite = dataE[i].ctl.memWrite;
            if (dataE[i].ctl.memWrite) begin
                dreq[i].data = wd[i];
                dreq[i].strobe = strobe[i];
            end
        end
    end

    always_comb begin
        ctlM[1] = dataE[1].ctl;
        ctlM[0] = dataE[0].ctl;
        // older lane traps, so the younger one must not write back
        if (laneExcp[1]) begin
            ctlM[0].regWrite = 1'b0;
            ctlM[0].memToReg = 1'b0;
        end
    end

    assign excpM = |laneExcp;

endmodule

`default_nettype wire

// File: respTimer.sv
`timescale 1ns/1ps
`default_nettype none

module respTimer (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic clear,
    output logic expired
);

    logic [pipePkg::TIMER_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count <= '0;
        end else if (run && !expired) begin
            count <= count + 1'b1;
        end
    end

    // holds at the limit until cleared
    assign expired = (count == pipePkg::TIMER_W'(pipePkg::TIMEOUT_CYCLES));

endmodule

`default_nettype wire

// File: stageReg.sv
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  T     inData,
    output logic inReady,
    output logic outValid,
    output T     outData,
    input  logic outReady
);

    // free slot, or the current entry leaves this cycle
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData <= inData;
        end
    end

endmodule

`default_nettype wire

// File: dbusFsm.sv
`timescale 1ns/1ps
`default_nettype none

module dbusFsm (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pairValid,
    output logic                 pairPop,
    input  pipePkg::dreq_t [1:0] dreq,
    output logic                 resultLoad,
    input  logic                 resultReady,
    output pipePkg::word_t [1:0] rword,
    output logic [1:0]           busErr,
    output logic                 timerRun,
    output logic                 timerClear,
    input  logic                 timerExpired,
    output pipePkg::word_t       awaddr,
    output logic                 awvalid,
    input  logic                 awready,
    output pipePkg::word_t       wdata,
    output pipePkg::strobe_t     wstrb,
    output logic                 wvalid,
    input  logic                 wready,
    input  logic [1:0]           bresp,
    input  logic                 bvalid,
    output logic                 bready,
    output pipePkg::word_t       araddr,
    output logic                 arvalid,
    input  logic                 arready,
    input  pipePkg::word_t       rdata,
    input  logic [1:0]           rresp,
    input  logic                 rvalid,
    output logic                 rready
);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        WAIT_RESP,
        NEXT_LANE,
        FINISH
    } state_t;

    state_t state;
    logic lane;
    logic awDone;
    logic wDone;
    pipePkg::dreq_t cur;

    assign cur = dreq[lane];

    // payload comes straight from the held pair, stable while valid
    assign awaddr = cur.addr;
    assign wdata = cur.data;
    assign wstrb = cur.strobe;
    assign araddr = cur.addr;

    assign awvalid = (state == ISSUE) && cur.isWrite && !awDone;
    assign wvalid = (state == ISSUE) && cur.isWrite && !wDone;
    assign arvalid = (state == ISSUE) && !cur.isWrite;
    assign bready = (state == WAIT_RESP) && cur.isWrite;
    assign rready = (state == WAIT_RESP) && !cur.isWrite;

    assign timerRun = (state == WAIT_RESP);
    assign timerClear = (state != WAIT_RESP);

    assign resultLoad = (state == FINISH) && resultReady;
    assign pairPop = resultLoad;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            lane <= 1'b1;
            awDone <= 1'b0;
            wDone <= 1'b0;
            busErr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pairValid && resultReady) begin
                        busErr <= '0;
                        // older lane first, skip lanes with no access
                        if (dreq[1].valid) begin
                            lane <= 1'b1;
                            state <= ISSUE;
                        end else if (dreq[0].valid) begin
                            lane <= 1'b0;
                            state <= ISSUE;
                        end else begin
                            state <= FINISH;
                        end
                    end
                end
                ISSUE: begin
                    if (cur.isWrite) begin
                        if (awvalid && awready) begin
                            awDone <= 1'b1;
                        end
                        if (wvalid && wready) begin
                            wDone <= 1'b1;
                        end
                        // AW and W may complete in either order
                        if ((awDone || awready) && (wDone || wready)) begin
                            awDone <= 1'b0;
                            wDone <= 1'b0;
                            state <= WAIT_RESP;
                        end
                    end else if (arready) begin
                        state <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (cur.isWrite && bvalid) begin
                        busErr[lane] <= (bresp != pipePkg::RESP_OKAY);
                        state <= NEXT_LANE;
                    end else if (!cur.isWrite && rvalid) begin
                        busErr[lane] <= (rresp != pipePkg::RESP_OKAY);
                        state <= NEXT_LANE;
                    end else if (timerExpired) begin
                        // give up on this beat
                        busErr[lane] <= 1'b1;
                        state <= NEXT_LANE;
                    end
                end
                NEXT_LANE: begin
                    if (lane && dreq[0].valid) begin
                        lane <= 1'b0;
                        state <= ISSUE;
                    end else begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    if (resultReady) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // read data per lane
    always_ff @(posedge clk) begin
        if (rready && rvalid) begin
            rword[lane] <= rdata;
        end
    end

endmodule

`default_nettype wire

// File: memStageTop.sv
`timescale 1ns/1ps
`default_nettype none

module memStageTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               inValid,
    input  pipePkg::execPair_t inPair,
    output logic               inReady,
    output logic               outValid,
    output pipePkg::memPair_t  outPair,
    output logic               excpM,
    input  logic               outReady,
    output pipePkg::word_t     awaddr,
    output logic               awvalid,
    input  logic               awready,
    output pipePkg::word_t     wdata,
    output pipePkg::strobe_t   wstrb,
    output logic               wvalid,
    input  logic               wready,
    input  logic [1:0]         bresp,
    input  logic               bvalid,
    output logic               bready,
    output pipePkg::word_t     araddr,
    output logic               arvalid,
    input  logic               arready,
    input  pipePkg::word_t     rdata,
    input  logic [1:0]         rresp,
    input  logic               rvalid,
    output logic               rready
);

    pipePkg::execPair_t dataE;
    logic pairValid;
    logic pairPop;
    pipePkg::dreq_t [1:0] dreq;
    pipePkg::memCtl_t [1:0] ctlM;
    logic excpE;
    logic resultLoad;
    logic resultReady;
    pipePkg::word_t [1:0] rword;
    logic [1:0] busErr;
    logic timerRun;
    logic timerClear;
    logic timerExpired;
    pipePkg::word_t [1:0] loadData;
    pipePkg::memPair_t resultPair;

    stageReg #(.T(pipePkg::execPair_t)) inReg (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inData   (inPair),
        .inReady  (inReady),
        .outValid (pairValid),
        .outData  (dataE),
        .outReady (pairPop)
    );

    memory memory0 (
        .dataE (dataE),
        .dreq  (dreq),
        .ctlM  (ctlM),
        .excpM (excpE)
    );

    dbusFsm dbusFsm0 (
        .clk          (clk),
        .rst          (rst),
        .pairValid    (pairValid),
        .pairPop      (pairPop),
        .dreq         (dreq),
        .resultLoad   (resultLoad),
        .resultReady  (resultReady),
        .rword        (rword),
        .busErr       (busErr),
        .timerRun     (timerRun),
        .timerClear   (timerClear),
        .timerExpired (timerExpired),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    respTimer respTimer0 (
        .clk     (clk),
        .rst     (rst),
        .run     (timerRun),
        .clear   (timerClear),
        .expired (timerExpired)
    );

    for (genvar i = 0; i < 2; i++) begin : gLoad
        readData readDataLane (
            .addr      (dataE[i].aluOut[1:0]),
            .rdata     (rword[i]),
            .msize     (ctlM[i].msize),
            .memSigned (ctlM[i].memSigned),
            .loadData  (loadData[i])
        );
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            resultPair[i].valid = dataE[i].valid;
            resultPair[i].pc = dataE[i].pc;
            resultPair[i].rdst = dataE[i].rdst;
            resultPair[i].aluOut = dataE[i].aluOut;
            resultPair[i].srcb = dataE[i].srcb;
            resultPair[i].ctl = ctlM[i];
            resultPair[i].ctype = dataE[i].ctype;
            // only a read that actually went out returns load data
            resultPair[i].result = (dreq[i].valid && ctlM[i].memToReg) ?
                                   loadData[i] : dataE[i].aluOut;
            resultPair[i].busErr = busErr[i];
            resultPair[i].excpM = excpE;
        end
    end

    stageReg #(.T(pipePkg::memPair_t)) outReg (
        .clk      (clk),
        .rst      (rst),
        .inValid  (resultLoad),
        .inData   (resultPair),
        .inReady  (resultReady),
        .outValid (outValid),
        .outData  (outPair),
        .outReady (outReady)
    );

    assign excpM = outPair[1].excpM;

endmodule

`default_nettype wire

// File: memStageTb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module memStageTb_asserts (
    input logic                 clk,
    input logic                 rst,
    input pipePkg::word_t       awaddr,
    input logic                 awvalid,
    input logic                 awready,
    input pipePkg::word_t       wdata,
    input pipePkg::strobe_t     wstrb,
    input logic                 wvalid,
    input logic                 wready,
    input pipePkg::word_t       araddr,
    input logic                 arvalid,
    input logic                 arready,
    input logic                 resultLoad,
    input logic                 resultReady
);

    // a raised valid waits for its ready with the payload held
    awHeld: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr changed before awready");

    wHeld: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("wvalid dropped or write payload changed before wready");

    arHeld: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before arready");

    // one beat at a time, never a read and a write together
    noAwAr: assert property (@(posedge clk) disable iff (rst)
        !(awvalid && arvalid))
        else $error("awvalid and arvalid high in the same cycle");

    loadWhenReady: assert property (@(posedge clk) disable iff (rst)
        resultLoad |-> resultReady)
        else $error("result loaded while the output register was full");

endmodule

bind dbusFsm memStageTb_asserts dbusAsserts0 (
    .clk         (clk),
    .rst         (rst),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .resultLoad  (resultLoad),
    .resultReady (resultReady)
);

`default_nettype wire

// File: memStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module memStageTb;

    // one predicted bus beat
    typedef struct packed {
        logic             isWrite;
        pipePkg::word_t   addr;
        pipePkg::word_t   data;
        pipePkg::strobe_t strobe;
        logic             drop;
    } access_t;

    localparam int NUM_PAIRS = 300;
    localparam int WAIT_LIMIT = 500;

    logic clk;
    logic rst;
    logic inValid;
    pipePkg::execPair_t inPair;
    logic inReady;
    logic outValid;
    pipePkg::memPair_t outPair;
    logic excpM;
    logic outReady;
    pipePkg::word_t awaddr;
    logic awvalid;
    logic awready;
    pipePkg::word_t wdata;
    pipePkg::strobe_t wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    pipePkg::word_t araddr;
    logic arvalid;
    logic arready;
    pipePkg::word_t rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;

    pipePkg::word_t slvMem [256];
    pipePkg::word_t refMem [256];
    access_t expAccess [$];
    pipePkg::memPair_t expPairs [$];
    logic expExcp [$];
    pipePkg::word_t lastRead [2];
    logic [1:0] readSeen;

    int pairErrors;
    int excpErrors;
    int writeErrors;
    int readErrors;
    int memErrors;
    int seqErrors;

    memStageTop dut0 (.*);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    function automatic pipePkg::word_t fillWord(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a, ~a, a ^ 8'h5a, a + 8'hc3};
    endfunction

    // last four words of the window answer with SLVERR
    function automatic logic errAddr(input pipePkg::word_t a);
        return a[9:4] == 6'h3f;
    endfunction

    function automatic pipePkg::word_t errWord(input pipePkg::word_t a);
        return a ^ 32'hbad0_0bad;
    endfunction

    function automatic pipePkg::word_t mergeWord(input pipePkg::word_t old,
            input pipePkg::word_t d, input pipePkg::strobe_t s);
        pipePkg::word_t m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                m[8*b +: 8] = d[8*b +: 8];
            end
        end
        return m;
    endfunction

    function automatic void storeBeat(input logic [1:0] off, input pipePkg::word_t v,
            input pipePkg::msize_t sz, output pipePkg::word_t d,
            output pipePkg::strobe_t s);
        int nbytes;
        nbytes = 1 << sz;
        for (int b = 0; b < 4; b++) begin
            d[8*b +: 8] = v[8*(b % nbytes) +: 8];
            s[b] = (b >= off) && (b < off + nbytes);
        end
    endfunction

    function automatic pipePkg::word_t extendLoad(input logic [1:0] off,
            input pipePkg::word_t w, input pipePkg::msize_t sz, input logic sgn);
        logic [7:0] b;
        logic [15:0] h;
        b = w >> (8 * off);
        h = w >> (16 * off[1]);
        if (sz == pipePkg::MSIZE1) begin
            return {{24{sgn && b[7]}}, b};
        end else if (sz == pipePkg::MSIZE2) begin
            return {{16{sgn && h[15]}}, h};
        end
        return w;
    endfunction

    function automatic pipePkg::execData_t randomLane();
        pipePkg::execData_t d;
        int kind;
        int c;
        d = '0;
        kind = $urandom % 3;
        d.valid = 1'b1;
        d.pc = $urandom & 32'hffff_fffc;
        d.rdst = 5'($urandom);
        d.srcb = $urandom;
        d.ctl.msize = pipePkg::msize_t'($urandom % 3);
        d.ctl.memSigned = 1'($urandom);
        if (kind == 0) begin
            d.aluOut = $urandom;
            d.ctl.regWrite = 1'($urandom);
        end else begin
            // aligned address inside the 1 KiB slave window
            d.aluOut = {22'd0, 8'($urandom), 2'b00};
            if (d.ctl.msize == pipePkg::MSIZE1) begin
                d.aluOut[1:0] = 2'($urandom);
            end else if (d.ctl.msize == pipePkg::MSIZE2) begin
                d.aluOut[1] = 1'($urandom);
            end
            d.ctl.memToReg = (kind == 1);
            d.ctl.memWrite = (kind == 2);
            d.ctl.regWrite = (kind == 1);
        end
        c = $urandom % 10;
        d.ctype = (c == 0) ? cp0Pkg::EXCEPTION : (c == 1) ? cp0Pkg::ERET : cp0Pkg::NONE;
        return d;
    endfunction

    // reference model, runs when a pair is accepted
    task automatic predictPair(input pipePkg::execPair_t p);
        pipePkg::memPair_t m;
        logic [1:0] excp;
        logic reqValid;
        access_t a;
        excp[1] = p[1].ctype != cp0Pkg::NONE;
        excp[0] = p[0].ctype != cp0Pkg::NONE;
        m = '0;
        for (int i = 1; i >= 0; i--) begin
            m[i].valid = p[i].valid;
            m[i].pc = p[i].pc;
            m[i].rdst = p[i].rdst;
            m[i].aluOut = p[i].aluOut;
            m[i].srcb = p[i].srcb;
            m[i].ctl = p[i].ctl;
            m[i].ctype = p[i].ctype;
            m[i].result = p[i].aluOut;
            m[i].excpM = |excp;
            // older lane traps, younger lane loses write-back
            if (i == 0 && excp[1]) begin
                m[0].ctl.regWrite = 1'b0;
                m[0].ctl.memToReg = 1'b0;
            end
            reqValid = (p[i].ctl.memToReg || p[i].ctl.memWrite) && !excp[i] &&
                       !(i == 0 && excp[1]);
            if (reqValid) begin
                a = '0;
                a.isWrite = p[i].ctl.memWrite;
                a.addr = p[i].aluOut;
                a.drop = ($urandom % 40) == 0;
                // a dropped first read would leave nothing known to return
                if (!a.isWrite && !readSeen[i]) begin
                    a.drop = 1'b0;
                end
                m[i].busErr = a.drop || errAddr(a.addr);
                if (a.isWrite) begin
                    storeBeat(a.addr[1:0], p[i].srcb, p[i].ctl.msize, a.data, a.strobe);
                    if (!m[i].busErr) begin
                        refMem[a.addr[9:2]] = mergeWord(refMem[a.addr[9:2]], a.data, a.strobe);
                    end
                end else begin
                    if (!a.drop) begin
                        lastRead[i] = errAddr(a.addr) ? errWord(a.addr) : refMem[a.addr[9:2]];
                        readSeen[i] = 1'b1;
                    end
                    m[i].result = extendLoad(a.addr[1:0], lastRead[i], p[i].ctl.msize,
                                             p[i].ctl.memSigned);
                end
                expAccess.push_back(a);
            end
        end
        expPairs.push_back(m);
        expExcp.push_back(|excp);
    endtask

    task automatic checkPair(input pipePkg::memPair_t got, input pipePkg::memPair_t exp);
        for (int i = 1; i >= 0; i--) begin
            if (got[i] !== exp[i]) begin
                pairErrors++;
                $display("ERROR @%0t: lane %0d pc %h result %h busErr %b ctl %h, expected %h %b %h",
                         $time, i, exp[i].pc, got[i].result, got[i].busErr, got[i].ctl,
                         exp[i].result, exp[i].busErr, exp[i].ctl);
            end
        end
    endtask

    task automatic checkExcp(input logic got, input logic exp);
        if (got !== exp) begin
            excpErrors++;
            $display("ERROR @%0t: excpM %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic checkWrite(input pipePkg::word_t addr, input pipePkg::strobe_t strb,
            input pipePkg::word_t data, input pipePkg::word_t expAddr,
            input pipePkg::strobe_t expStrb, input pipePkg::word_t expData);
        if (addr !== expAddr || strb !== expStrb || data !== expData) begin
            writeErrors++;
            $display("ERROR @%0t: write addr %h strb %b data %h, expected %h %b %h",
                     $time, addr, strb, data, expAddr, expStrb, expData);
        end
    endtask

    task automatic checkRead(input pipePkg::word_t addr, input pipePkg::word_t expAddr);
        if (addr !== expAddr) begin
            readErrors++;
            $display("ERROR @%0t: read addr %h, expected %h", $time, addr, expAddr);
        end
    endtask

    task automatic checkWord(input int idx, input pipePkg::word_t got,
            input pipePkg::word_t exp);
        if (got !== exp) begin
            memErrors++;
            $display("ERROR @%0t: memory word %0d holds %h, expected %h", $time, idx, got, exp);
        end
    endtask

    function automatic int totalErrors();
        return pairErrors + excpErrors + writeErrors + readErrors + memErrors + seqErrors;
    endfunction

    task automatic printCounts();
        $display("errors: pair %0d excp %0d write %0d read %0d memory %0d sequence %0d",
                 pairErrors, excpErrors, writeErrors, readErrors, memErrors, seqErrors);
    endtask

    task automatic failTimeout(input string what);
        $display("timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        printCounts();
        $display("Regression failed");
        $finish;
    endtask

    task automatic awaitAbandon();
        int w;
        w = 0;
        while (bready || rready) begin
            if (w == WAIT_LIMIT) begin
                failTimeout("the DUT to abandon an unanswered beat");
            end
            @(negedge clk);
            w++;
        end
    endtask

    // AXI4-Lite slave, one beat at a time
    initial begin : slave
        access_t a;
        pipePkg::word_t addr;
        forever begin
            @(negedge clk);
            if (!rst && (awvalid || arvalid)) begin
                if (expAccess.size() == 0) begin
                    seqErrors++;
                    $display("bus access at %0t with none predicted", $time);
                    a = '0;
                    a.isWrite = awvalid;
                    a.addr = awvalid ? awaddr : araddr;
                end else begin
                    a = expAccess.pop_front();
                end
                if (a.isWrite != awvalid) begin
                    seqErrors++;
                    $display("bus access at %0t is not of the predicted kind", $time);
                end
                addr = awvalid ? awaddr : araddr;
                repeat ($urandom % 6) @(negedge clk);
                if (awvalid) begin
                    // write data travels with the write address
                    if (!wvalid) begin
                        seqErrors++;
                        $display("wvalid low at %0t while awvalid waits for awready", $time);
                    end
                    checkWrite(awaddr, wstrb, wdata, a.addr, a.strobe, a.data);
                    awready = 1'b1;
                    wready = 1'b1;
                    @(negedge clk);
                    awready = 1'b0;
                    wready = 1'b0;
                    if (!a.drop && !errAddr(addr)) begin
                        slvMem[addr[9:2]] = mergeWord(slvMem[addr[9:2]], wdata, wstrb);
                    end
                end else begin
                    checkRead(araddr, a.addr);
                    arready = 1'b1;
                    @(negedge clk);
                    arready = 1'b0;
                end
                if (a.drop) begin
                    awaitAbandon();
                end else begin
                    repeat ($urandom % 6) @(negedge clk);
                    if (bready) begin
                        bresp = errAddr(addr) ? 2'b10 : 2'b00;
                        bvalid = 1'b1;
                    end else begin
                        rdata = errAddr(addr) ? errWord(addr) : slvMem[addr[9:2]];
                        rresp = errAddr(addr) ? 2'b10 : 2'b00;
                        rvalid = 1'b1;
                    end
                    @(negedge clk);
                    bvalid = 1'b0;
                    rvalid = 1'b0;
                    bresp = 2'b00;
                    rresp = 2'b00;
                end
            end
        end
    end

    // random back-pressure
    always @(negedge clk) begin
        outReady = ($urandom % 4) != 0;
    end

    always @(negedge clk) begin
        #1;
        if (!rst && outValid && outReady) begin
            if (expPairs.size() == 0) begin
                seqErrors++;
                $display("output pair at %0t with no pair outstanding", $time);
            end else begin
                checkPair(outPair, expPairs.pop_front());
                checkExcp(excpM, expExcp.pop_front());
            end
        end
    end

    initial begin : stimulus
        int waitCount;
        pipePkg::execPair_t p;
        void'($urandom(32'h1009e276));
        rst = 1'b1;
        inValid = 1'b0;
        inPair = '0;
        outReady = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bresp = 2'b00;
        bvalid = 1'b0;
        arready = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        rvalid = 1'b0;
        readSeen = '0;
        for (int i = 0; i < 256; i++) begin
            slvMem[i] = fillWord(i);
            refMem[i] = fillWord(i);
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < NUM_PAIRS; n++) begin
            repeat ($urandom % 3) @(negedge clk);
            p[1] = randomLane();
            p[0] = randomLane();
            inValid = 1'b1;
            inPair = p;
            waitCount = 0;
            #1;
            while (!inReady) begin
                if (waitCount == WAIT_LIMIT) begin
                    failTimeout("inReady");
                end
                @(negedge clk);
                #1;
                waitCount++;
            end
            // accepted on the coming rising edge
            predictPair(p);
            @(negedge clk);
            inValid = 1'b0;
        end
        waitCount = 0;
        while (expPairs.size() != 0) begin
            if (waitCount == WAIT_LIMIT) begin
                failTimeout("the remaining output pairs");
            end
            @(negedge clk);
            waitCount++;
        end
        repeat (4) @(negedge clk);
        if (expAccess.size() != 0) begin
            seqErrors++;
            $display("%0d predicted bus accesses never appeared", expAccess.size());
        end
        for (int i = 0; i < 256; i++) begin
            checkWord(i, slvMem[i], refMem[i]);
        end
        printCounts();
        if (totalErrors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
cp0Pkg.sv
pipePkg.sv
writeData.sv
readData.sv
memory.sv
respTimer.sv
stageReg.sv
dbusFsm.sv
memStageTop.sv
memStageTb_asserts.sv
memStageTb.sv
